// ==== src/periph_hub_pkg.sv ====
package periph_hub_pkg;

    // byte bus payload types
    typedef logic [31:0] bus_addr_t;
    typedef logic [7:0]  bus_data_t;

    // peripheral state widths
    typedef logic [15:0] timer_count_t;
    typedef logic [15:0] lfsr_state_t;

    // bus cycle machine
    typedef enum logic [1:0] {
        IDLE,
        STROBE,
        WAIT_ACK,
        RESPOND
    } cycle_state_t;

    // timer window, 0xFFFFFDxx
    localparam bus_addr_t TIMER_BASE = 32'hFFFF_FD00;

    // generator window, 0xFFFFFExx
    localparam bus_addr_t PRNG_BASE = 32'hFFFF_FE00;

    // led window, 0xFFFFFFFx
    localparam bus_addr_t LED_BASE = 32'hFFFF_FFF0;

    // generator state after reset
    localparam lfsr_state_t LFSR_RESET_SEED = 16'hACE1;

endpackage

// ==== src/wb8_if.sv ====
`timescale 1ns/1ps

interface wb8_if;
    import periph_hub_pkg::*;

    bus_addr_t adr;
    bus_data_t wdat;
    logic      we;
    logic      stb;
    logic      ack;
    bus_data_t rdat;

    // cycle initiator
    modport master (
        output adr,
        output wdat,
        output we,
        output stb,
        input  ack,
        input  rdat
    );

    // responding side
    modport slave (
        input  adr,
        input  wdat,
        input  we,
        input  stb,
        output ack,
        output rdat
    );

endinterface

// ==== src/reset_sequencer.sv ====
`timescale 1ns/1ps

module reset_sequencer #(
    parameter int RESET_HOLD_CYCLES = 32
) (
    input  logic clk,
    input  logic rst_n_i,
    input  logic reset_req_n_i,
    output logic sys_rst_o
);

    localparam int CNT_W = $clog2(RESET_HOLD_CYCLES + 1);
    localparam logic [CNT_W-1:0] HOLD_LOAD = CNT_W'(RESET_HOLD_CYCLES);

    logic [CNT_W-1:0] hold_cnt_q;
    logic             req_low;

    // either source restarts the hold window
    assign req_low = ~rst_n_i | ~reset_req_n_i;

    always_ff @(posedge clk) begin
        if (req_low) begin
            hold_cnt_q <= HOLD_LOAD;
        end else if (hold_cnt_q != '0) begin
            hold_cnt_q <= hold_cnt_q - 1'b1;
        end
    end

    // internal reset lasts until the counter drains
    assign sys_rst_o = (hold_cnt_q != '0);

endmodule

// ==== src/bus_cycle_fsm.sv ====
`timescale 1ns/1ps

module bus_cycle_fsm (
    input  logic                      clk,
    input  logic                      sys_rst_i,
    input  logic                      req_valid_i,
    input  logic                      req_write_i,
    input  periph_hub_pkg::bus_addr_t req_addr_i,
    input  periph_hub_pkg::bus_data_t req_wdata_i,
    output logic                      req_ready_o,
    output logic                      rsp_valid_o,
    output periph_hub_pkg::bus_data_t rsp_rdata_o,
    wb8_if.master                     bus
);
    import periph_hub_pkg::*;

    cycle_state_t state_q;
    cycle_state_t state_d;
    logic         ready_q;
    logic         accept;
    logic         ack_seen;
    bus_addr_t    adr_q;
    bus_data_t    wdat_q;
    logic         we_q;
    bus_data_t    rdata_q;

    assign accept = req_valid_i & req_ready_o;

    // ack counts only while a cycle is outstanding
    assign ack_seen = bus.ack & ((state_q == STROBE) | (state_q == WAIT_ACK));

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    state_d = STROBE;
                end
            end
            // unmapped addresses ack right away and skip the wait
            STROBE: begin
                state_d = bus.ack ? RESPOND : WAIT_ACK;
            end
            WAIT_ACK: begin
                if (bus.ack) begin
                    state_d = RESPOND;
                end
            end
            RESPOND: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (sys_rst_i) begin
            state_q <= IDLE;
            ready_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // ready comes back one cycle after the response pulse
            ready_q <= (state_d == IDLE);
        end
    end

    // request held for the whole bus cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            adr_q  <= req_addr_i;
            wdat_q <= req_wdata_i;
            we_q   <= req_write_i;
        end
    end

    // read byte is only valid with ack and writes answer zero
    always_ff @(posedge clk) begin
        if (ack_seen) begin
            rdata_q <= we_q ? '0 : bus.rdat;
        end
    end

    assign bus.adr  = adr_q;
    assign bus.wdat = wdat_q;
    assign bus.we   = we_q;
    assign bus.stb  = (state_q == STROBE);

    // no request is taken while the internal reset is up
    assign req_ready_o = ready_q & ~sys_rst_i;
    assign rsp_valid_o = (state_q == RESPOND);
    assign rsp_rdata_o = rdata_q;

endmodule

// ==== src/addr_decoder.sv ====
`timescale 1ns/1ps

module addr_decoder (
    wb8_if.slave  core,
    wb8_if.master timer_bus,
    wb8_if.master prng_bus,
    wb8_if.master led_bus
);
    import periph_hub_pkg::*;

    logic sel_timer;
    logic sel_prng;
    logic sel_led;

    // timer and generator decode on a 256 byte page, leds on 16 bytes
    assign sel_timer = (core.adr[31:8] == TIMER_BASE[31:8]);
    assign sel_prng  = (core.adr[31:8] == PRNG_BASE[31:8]);
    assign sel_led   = (core.adr[31:4] == LED_BASE[31:4]);

    // shared lines go to every peripheral
    assign timer_bus.adr  = core.adr;
    assign timer_bus.wdat = core.wdat;
    assign timer_bus.we   = core.we;
    assign prng_bus.adr   = core.adr;
    assign prng_bus.wdat  = core.wdat;
    assign prng_bus.we    = core.we;
    assign led_bus.adr    = core.adr;
    assign led_bus.wdat   = core.wdat;
    assign led_bus.we     = core.we;

    // only the selected peripheral sees the strobe
    assign timer_bus.stb = core.stb & sel_timer;
    assign prng_bus.stb  = core.stb & sel_prng;
    assign led_bus.stb   = core.stb & sel_led;

    always_comb begin
        if (sel_timer) begin
            core.ack  = timer_bus.ack;
            core.rdat = timer_bus.rdat;
        end else if (sel_prng) begin
            core.ack  = prng_bus.ack;
            core.rdat = prng_bus.rdat;
        end else if (sel_led) begin
            core.ack  = led_bus.ack;
            core.rdat = led_bus.rdat;
        end else begin
            // nothing mapped here, answer in the strobe cycle with zero
            core.ack  = core.stb;
            core.rdat = '0;
        end
    end

endmodule

// ==== src/led_register.sv ====
`timescale 1ns/1ps

module led_register (
    input  logic                      clk,
    input  logic                      sys_rst_i,
    wb8_if.slave                      bus,
    output periph_hub_pkg::bus_data_t leds_o
);
    import periph_hub_pkg::*;

    bus_data_t leds_q;
    logic      ack_q;

    always_ff @(posedge clk) begin
        if (sys_rst_i) begin
            leds_q <= '0;
            ack_q  <= 1'b0;
        end else begin
            ack_q <= bus.stb;
            if (bus.stb && bus.we) begin
                leds_q <= bus.wdat;
            end
        end
    end

    // whole window reads back the stored byte
    assign bus.rdat = leds_q;
    assign bus.ack  = ack_q;
    assign leds_o   = leds_q;

endmodule

// ==== src/interval_timer.sv ====
`timescale 1ns/1ps

module interval_timer #(
    parameter int TIMER_PRESCALE = 4
) (
    input  logic clk,
    input  logic sys_rst_i,
    wb8_if.slave bus,
    output logic irq_o
);
    import periph_hub_pkg::*;

    localparam int PRE_W = (TIMER_PRESCALE > 1) ? $clog2(TIMER_PRESCALE) : 1;
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(TIMER_PRESCALE - 1);

    timer_count_t     reload_q;
    timer_count_t     count_q;
    logic [PRE_W-1:0] pre_q;
    logic             enable_q;
    logic             irq_en_q;
    logic             pending_q;
    logic             ack_q;
    bus_data_t        rdat_q;
    logic [7:0]       offset;
    logic             wr;
    logic             rd;
    logic             start;
    logic             tick;
    logic             wrap;

    assign offset = bus.adr[7:0];
    assign wr     = bus.stb & bus.we;
    assign rd     = bus.stb & ~bus.we;

    // enable going from 0 to 1 restarts the count
    assign start = wr & (offset == 8'd2) & bus.wdat[0] & ~enable_q;
    assign tick  = enable_q & (pre_q == PRE_LAST);
    assign wrap  = tick & (count_q <= 16'd1);

    always_ff @(posedge clk) begin
        if (sys_rst_i) begin
            reload_q <= '0;
            enable_q <= 1'b0;
            irq_en_q <= 1'b0;
        end else if (wr) begin
            case (offset)
                8'd0: reload_q[7:0]  <= bus.wdat;
                8'd1: reload_q[15:8] <= bus.wdat;
                8'd2: begin
                    enable_q <= bus.wdat[0];
                    irq_en_q <= bus.wdat[1];
                end
                default: ;
            endcase
        end
    end

    // prescaler and down counter
    always_ff @(posedge clk) begin
        if (sys_rst_i) begin
            count_q <= '0;
            pre_q   <= '0;
        end else if (start) begin
            count_q <= reload_q;
            pre_q   <= '0;
        end else if (enable_q) begin
            pre_q <= tick ? '0 : pre_q + 1'b1;
            if (wrap) begin
                count_q <= reload_q;
            end else if (tick) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // sticky flag, a wrap wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (sys_rst_i) begin
            pending_q <= 1'b0;
        end else if (wrap) begin
            pending_q <= 1'b1;
        end else if (wr && offset == 8'd3 && bus.wdat[0]) begin
            pending_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (sys_rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= bus.stb;
        end
    end

    always_ff @(posedge clk) begin
        if (rd) begin
            case (offset)
                8'd0:    rdat_q <= reload_q[7:0];
                8'd1:    rdat_q <= reload_q[15:8];
                8'd2:    rdat_q <= {6'd0, irq_en_q, enable_q};
                8'd3:    rdat_q <= {7'd0, pending_q};
                8'd4:    rdat_q <= count_q[7:0];
                8'd5:    rdat_q <= count_q[15:8];
                default: rdat_q <= '0;
            endcase
        end
    end

    assign bus.ack  = ack_q;
    assign bus.rdat = rdat_q;
    assign irq_o    = pending_q & irq_en_q;

endmodule

// ==== src/prng_lfsr.sv ====
`timescale 1ns/1ps

module prng_lfsr (
    input  logic clk,
    input  logic sys_rst_i,
    wb8_if.slave bus
);
    import periph_hub_pkg::*;

    lfsr_state_t state_q;
    lfsr_state_t state_step;
    logic        feedback;
    logic        ack_q;
    bus_data_t   rdat_q;
    logic        wr;
    logic        rd;

    assign wr = bus.stb & bus.we;
    assign rd = bus.stb & ~bus.we;

    // fibonacci taps 16, 14, 13, 11
    assign feedback   = state_q[15] ^ state_q[13] ^ state_q[12] ^ state_q[10];
    assign state_step = {state_q[14:0], feedback};

    always_ff @(posedge clk) begin
        if (sys_rst_i) begin
            state_q <= LFSR_RESET_SEED;
            ack_q   <= 1'b0;
        end else begin
            ack_q <= bus.stb;
            if (wr && bus.adr[7:0] == 8'd0) begin
                state_q[7:0] <= bus.wdat;
            end else if (wr && bus.adr[7:0] == 8'd1) begin
                state_q[15:8] <= bus.wdat;
            end else if (rd && bus.adr[7:0] == 8'd0) begin
                // low byte read consumes one step
                state_q <= state_step;
            end
        end
    end

    // sampled before the step lands
    always_ff @(posedge clk) begin
        if (rd) begin
            case (bus.adr[7:0])
                8'd0:    rdat_q <= state_q[7:0];
                8'd1:    rdat_q <= state_q[15:8];
                default: rdat_q <= '0;
            endcase
        end
    end

    assign bus.ack  = ack_q;
    assign bus.rdat = rdat_q;

endmodule

// ==== src/periph_hub.sv ====
`timescale 1ns/1ps

module periph_hub #(
    parameter int RESET_HOLD_CYCLES = 32,
    parameter int TIMER_PRESCALE    = 4
) (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      reset_req_n_i,
    input  logic                      req_valid_i,
    output logic                      req_ready_o,
    input  logic                      req_write_i,
    input  periph_hub_pkg::bus_addr_t req_addr_i,
    input  periph_hub_pkg::bus_data_t req_wdata_i,
    output logic                      rsp_valid_o,
    output periph_hub_pkg::bus_data_t rsp_rdata_o,
    output periph_hub_pkg::bus_data_t leds_o,
    output logic                      timer_irq_o,
    output logic                      sys_rst_o
);

    // host side of the decoder, plus one link per peripheral
    wb8_if core ();
    wb8_if timer_bus ();
    wb8_if prng_bus ();
    wb8_if led_bus ();

    reset_sequencer #(
        .RESET_HOLD_CYCLES(RESET_HOLD_CYCLES)
    ) u_reset_sequencer (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .reset_req_n_i (reset_req_n_i),
        .sys_rst_o     (sys_rst_o)
    );

    bus_cycle_fsm u_bus_cycle_fsm (
        .clk         (clk),
        .sys_rst_i   (sys_rst_o),
        .req_valid_i (req_valid_i),
        .req_write_i (req_write_i),
        .req_addr_i  (req_addr_i),
        .req_wdata_i (req_wdata_i),
        .req_ready_o (req_ready_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_rdata_o (rsp_rdata_o),
        .bus         (core.master)
    );

    addr_decoder u_addr_decoder (
        .core      (core.slave),
        .timer_bus (timer_bus.master),
        .prng_bus  (prng_bus.master),
        .led_bus   (led_bus.master)
    );

    led_register u_led_register (
        .clk       (clk),
        .sys_rst_i (sys_rst_o),
        .bus       (led_bus.slave),
        .leds_o    (leds_o)
    );

    interval_timer #(
        .TIMER_PRESCALE(TIMER_PRESCALE)
    ) u_interval_timer (
        .clk       (clk),
        .sys_rst_i (sys_rst_o),
        .bus       (timer_bus.slave),
        .irq_o     (timer_irq_o)
    );

    prng_lfsr u_prng_lfsr (
        .clk       (clk),
        .sys_rst_i (sys_rst_o),
        .bus       (prng_bus.slave)
    );

endmodule

// ==== sim/tb_periph_hub.sv ====
`timescale 1ns/1ps

module tb_periph_hub;
    import periph_hub_pkg::*;

    localparam int RESET_HOLD_CYCLES = 32;
    localparam int TIMER_PRESCALE    = 4;
    localparam int BUS_TIMEOUT       = 50;
    localparam timer_count_t TIMER_RELOAD = 16'd8;

    logic         clk;
    logic         rst_n_i;
    logic         reset_req_n_i;
    logic         req_valid_i;
    logic         req_ready_o;
    logic         req_write_i;
    bus_addr_t    req_addr_i;
    bus_data_t    req_wdata_i;
    logic         rsp_valid_o;
    bus_data_t    rsp_rdata_o;
    bus_data_t    leds_o;
    logic         timer_irq_o;
    logic         sys_rst_o;

    int           error_count;
    int           timeout_count;
    bus_data_t    last_led;
    bus_data_t    rand_byte;
    lfsr_state_t  prng_model;
    timer_count_t reload_rd;

    // stimulus table columns
    string        tbl_name[$];
    logic         tbl_write[$];
    bus_addr_t    tbl_addr[$];
    bus_data_t    tbl_wdata[$];
    bus_data_t    tbl_exp[$];
    logic         tbl_check[$];

    initial clk = 1'b0;
    always #10 clk = ~clk;

    periph_hub #(
        .RESET_HOLD_CYCLES(RESET_HOLD_CYCLES),
        .TIMER_PRESCALE   (TIMER_PRESCALE)
    ) dut (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .reset_req_n_i (reset_req_n_i),
        .req_valid_i   (req_valid_i),
        .req_ready_o   (req_ready_o),
        .req_write_i   (req_write_i),
        .req_addr_i    (req_addr_i),
        .req_wdata_i   (req_wdata_i),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_rdata_o   (rsp_rdata_o),
        .leds_o        (leds_o),
        .timer_irq_o   (timer_irq_o),
        .sys_rst_o     (sys_rst_o)
    );

    task automatic check_data(input string name, input bus_data_t exp, input bus_data_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected 0x%02h, actual 0x%02h", name, exp, act);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            error_count++;
        end
    endtask

    task automatic check_count(input string name, input timer_count_t exp,
                               input timer_count_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected 0x%04h, actual 0x%04h", name, exp, act);
            error_count++;
        end
    endtask

    // fibonacci step with taps at bits 15, 13, 12 and 10
    function automatic lfsr_state_t next_lfsr_state(input lfsr_state_t s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one host transfer between two falling edges
    task automatic bus_xfer(input logic is_write, input bus_addr_t addr,
                            input bus_data_t wdata, output bus_data_t rdata);
        int cycles;
        rdata       = '0;
        req_valid_i = 1'b1;
        req_write_i = is_write;
        req_addr_i  = addr;
        req_wdata_i = wdata;
        cycles      = 0;
        while (req_ready_o !== 1'b1 && cycles < BUS_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (req_ready_o !== 1'b1) begin
            $display("timeout: req_ready_o never rose for address 0x%08h", addr);
            timeout_count++;
            req_valid_i = 1'b0;
        end else begin
            // accepted on the rising edge just passed
            @(negedge clk);
            req_valid_i = 1'b0;
            cycles      = 0;
            while (rsp_valid_o !== 1'b1 && cycles < BUS_TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if (rsp_valid_o !== 1'b1) begin
                $display("timeout: no response for address 0x%08h", addr);
                timeout_count++;
            end else begin
                rdata = rsp_rdata_o;
            end
        end
    endtask

    task automatic add_entry(input string name, input logic is_write, input bus_addr_t addr,
                             input bus_data_t wdata, input bus_data_t exp, input logic check);
        tbl_name.push_back(name);
        tbl_write.push_back(is_write);
        tbl_addr.push_back(addr);
        tbl_wdata.push_back(wdata);
        tbl_exp.push_back(exp);
        tbl_check.push_back(check);
    endtask

    task automatic run_table();
        bus_data_t rdata;
        for (int i = 0; i < tbl_name.size(); i++) begin
            bus_xfer(tbl_write[i], tbl_addr[i], tbl_wdata[i], rdata);
            if (tbl_check[i]) begin
                check_data(tbl_name[i], tbl_exp[i], rdata);
            end
        end
        tbl_name.delete();
        tbl_write.delete();
        tbl_addr.delete();
        tbl_wdata.delete();
        tbl_exp.delete();
        tbl_check.delete();
    endtask

    // ready must stay low until the internal reset drains
    task automatic wait_reset_release(input string name);
        int cycles;
        cycles = 0;
        while (sys_rst_o === 1'b1 && cycles < RESET_HOLD_CYCLES + 8) begin
            check_bit({name, " ready held low"}, 1'b0, req_ready_o);
            @(negedge clk);
            cycles++;
        end
        if (sys_rst_o !== 1'b0) begin
            $display("timeout: internal reset did not release during %s", name);
            timeout_count++;
        end else begin
            @(negedge clk);
            check_bit({name, " ready after release"}, 1'b1, req_ready_o);
        end
    endtask

    task automatic wait_for_irq(input string name, input int limit);
        int cycles;
        cycles = 0;
        while (timer_irq_o !== 1'b1 && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (timer_irq_o !== 1'b1) begin
            $display("timeout: timer_irq_o did not rise within %0d cycles (%s)", limit, name);
            timeout_count++;
        end
    endtask

    task automatic watch_irq_low(input string name, input int cycles);
        for (int i = 0; i < cycles; i++) begin
            check_bit(name, 1'b0, timer_irq_o);
            @(negedge clk);
        end
    endtask

    task automatic read_reload(output timer_count_t value);
        bus_data_t lo;
        bus_data_t hi;
        bus_xfer(1'b0, TIMER_BASE, 8'h00, lo);
        bus_xfer(1'b0, TIMER_BASE + 32'd1, 8'h00, hi);
        value = {hi, lo};
    endtask

    initial begin
        void'($urandom(13));
        error_count   = 0;
        timeout_count = 0;
        rst_n_i       = 1'b0;
        reset_req_n_i = 1'b1;
        req_valid_i   = 1'b0;
        req_write_i   = 1'b0;
        req_addr_i    = '0;
        req_wdata_i   = '0;

        // power-on reset
        repeat (16) @(negedge clk);
        rst_n_i = 1'b1;
        wait_reset_release("power-on reset");
        check_data("leds after reset", 8'h00, leds_o);
        check_bit("irq after reset", 1'b0, timer_irq_o);
        check_bit("rsp_valid after reset", 1'b0, rsp_valid_o);

        // led register
        for (int i = 0; i < 4; i++) begin
            rand_byte = bus_data_t'($urandom);
            add_entry($sformatf("led write %0d", i), 1'b1, LED_BASE, rand_byte, 8'h00, 1'b1);
            add_entry($sformatf("led read %0d", i), 1'b0, LED_BASE + i, 8'h00, rand_byte, 1'b1);
            last_led = rand_byte;
        end
        run_table();
        check_data("leds_o after writes", last_led, leds_o);

        // unmapped space reads zero and swallows writes
        add_entry("unmapped low read", 1'b0, 32'h0000_1234, 8'h00, 8'h00, 1'b1);
        add_entry("unmapped high read", 1'b0, 32'hFFFF_FA00, 8'h00, 8'h00, 1'b1);
        add_entry("unmapped write", 1'b1, 32'hFFFF_FA00, ~last_led, 8'h00, 1'b1);
        add_entry("unmapped gap read", 1'b0, 32'hFFFF_FF00, 8'h00, 8'h00, 1'b1);
        run_table();
        check_data("leds_o after unmapped write", last_led, leds_o);

        // generator seed after reset is 0xACE1, then a random seed
        add_entry("prng reset high", 1'b0, PRNG_BASE + 32'd1, 8'h00, 8'hAC, 1'b1);
        add_entry("prng reset low", 1'b0, PRNG_BASE, 8'h00, 8'hE1, 1'b1);
        prng_model = lfsr_state_t'($urandom);
        if (prng_model == '0) begin
            prng_model = 16'h0001;
        end
        add_entry("prng seed low", 1'b1, PRNG_BASE, prng_model[7:0], 8'h00, 1'b1);
        add_entry("prng seed high", 1'b1, PRNG_BASE + 32'd1, prng_model[15:8], 8'h00, 1'b1);
        for (int i = 0; i < 6; i++) begin
            add_entry($sformatf("prng step %0d", i), 1'b0, PRNG_BASE, 8'h00,
                      prng_model[7:0], 1'b1);
            prng_model = next_lfsr_state(prng_model);
        end
        add_entry("prng high byte", 1'b0, PRNG_BASE + 32'd1, 8'h00, prng_model[15:8], 1'b1);
        add_entry("prng after high read", 1'b0, PRNG_BASE, 8'h00, prng_model[7:0], 1'b1);
        run_table();

        // timer registers
        rand_byte = bus_data_t'($urandom);
        add_entry("timer hi write", 1'b1, TIMER_BASE + 32'd1, rand_byte, 8'h00, 1'b1);
        add_entry("timer hi read", 1'b0, TIMER_BASE + 32'd1, 8'h00, rand_byte, 1'b1);
        add_entry("timer lo write", 1'b1, TIMER_BASE, TIMER_RELOAD[7:0], 8'h00, 1'b1);
        add_entry("timer hi clear", 1'b1, TIMER_BASE + 32'd1, TIMER_RELOAD[15:8], 8'h00, 1'b1);
        add_entry("timer control idle", 1'b0, TIMER_BASE + 32'd2, 8'h00, 8'h00, 1'b1);
        add_entry("timer status idle", 1'b0, TIMER_BASE + 32'd3, 8'h00, 8'h00, 1'b1);
        add_entry("timer start", 1'b1, TIMER_BASE + 32'd2, 8'h03, 8'h00, 1'b1);
        run_table();
        read_reload(reload_rd);
        check_count("timer reload", TIMER_RELOAD, reload_rd);

        // first interrupt and its clear
        wait_for_irq("first wrap", TIMER_RELOAD * TIMER_PRESCALE + 16);
        add_entry("timer status pending", 1'b0, TIMER_BASE + 32'd3, 8'h00, 8'h01, 1'b1);
        add_entry("timer status clear", 1'b1, TIMER_BASE + 32'd3, 8'h01, 8'h00, 1'b1);
        run_table();
        check_bit("irq after status clear", 1'b0, timer_irq_o);

        // the flag still sets while masked but irq stays low
        add_entry("timer mask irq", 1'b1, TIMER_BASE + 32'd2, 8'h01, 8'h00, 1'b1);
        run_table();
        watch_irq_low("irq while masked", 2 * TIMER_RELOAD * TIMER_PRESCALE);
        add_entry("timer status masked", 1'b0, TIMER_BASE + 32'd3, 8'h00, 8'h01, 1'b1);
        add_entry("timer unmask irq", 1'b1, TIMER_BASE + 32'd2, 8'h03, 8'h00, 1'b1);
        run_table();
        wait_for_irq("unmasked pending", 8);

        // reset request pin mid-run
        reset_req_n_i = 1'b0;
        @(negedge clk);
        reset_req_n_i = 1'b1;
        check_bit("reset request asserts sys_rst", 1'b1, sys_rst_o);
        wait_reset_release("reset request");
        check_data("leds after reset request", 8'h00, leds_o);
        check_bit("irq after reset request", 1'b0, timer_irq_o);
        add_entry("led read after reset", 1'b0, LED_BASE, 8'h00, 8'h00, 1'b1);
        add_entry("timer control after reset", 1'b0, TIMER_BASE + 32'd2, 8'h00, 8'h00, 1'b1);
        add_entry("timer status after reset", 1'b0, TIMER_BASE + 32'd3, 8'h00, 8'h00, 1'b1);
        run_table();
        read_reload(reload_rd);
        check_count("timer reload after reset", 16'h0000, reload_rd);

        $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== periph_hub.f ====
src/periph_hub_pkg.sv
src/wb8_if.sv
src/reset_sequencer.sv
src/bus_cycle_fsm.sv
src/addr_decoder.sv
src/led_register.sv
src/interval_timer.sv
src/prng_lfsr.sv
src/periph_hub.sv
sim/tb_periph_hub.sv

// ==== Bender.yml ====
package:
  name: periph_hub

sources:
  - src/periph_hub_pkg.sv
  - src/wb8_if.sv
  - src/reset_sequencer.sv
  - src/bus_cycle_fsm.sv
  - src/addr_decoder.sv
  - src/led_register.sv
  - src/interval_timer.sv
  - src/prng_lfsr.sv
  - src/periph_hub.sv
  - target: simulation
    files:
      - sim/tb_periph_hub.sv
